//--- Makefile
# Verilator build and run for the jump issue slice

VERILATOR ?= verilator
TOP       ?= tb_jal_core
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= sim passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the exit status comes from the search for the pass line
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- design/jal_consts.svh
`ifndef JAL_CONSTS_SVH
`define JAL_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// jump issue slice sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// issue buffer slots and index width
`define JAL_ISSUE_DEPTH 4
`define JAL_ISSUE_IDX_W 2

// data and pc width
`define JAL_XLEN 64

// architectural registers
`define JAL_NREG 32
`define JAL_REG_W 5

`endif

//--- design/jal_core_top.sv
`include "jal_consts.svh"

module jal_core_top (
	input  logic                  CLK,
	input  logic                  reset,
	input  logic                  dispatch_valid,
	input  jal_pkg::jal_instr_u   dispatch_instr,
	input  logic [`JAL_XLEN-1:0]  dispatch_pc,
	input  logic                  dispatch_rvc,
	output logic                  buffer_full,
	input  logic                  ext_wb_valid,
	input  logic [`JAL_REG_W-1:0] ext_wb_rd,
	input  logic [`JAL_XLEN-1:0]  ext_wb_data,
	input  logic                  ext_busy_set,
	input  logic [`JAL_REG_W-1:0] ext_busy_rd,
	output logic                  redirect_valid,
	output logic [`JAL_XLEN-1:0]  redirect_pc,
	output logic                  wb_valid,
	output logic [`JAL_REG_W-1:0] wb_rd,
	output logic [`JAL_XLEN-1:0]  wb_data
);
	import jal_pkg::*;

	// buffer to controller
	logic [`JAL_ISSUE_DEPTH-1:0]                slot_valid;
	jal_instr_u [`JAL_ISSUE_DEPTH-1:0]          slot_instr;
	logic [`JAL_ISSUE_DEPTH-1:0][`JAL_XLEN-1:0] slot_pc;
	logic [`JAL_ISSUE_DEPTH-1:0]                slot_rvc;
	logic                                       pop;
	logic [`JAL_ISSUE_IDX_W-1:0]                pop_index;

	// controller and register file
	logic [`JAL_NREG-1:0]  busy;
	logic [`JAL_REG_W-1:0] rs1_addr;
	logic [`JAL_XLEN-1:0]  rs1_data;
	logic                  busy_set;
	logic [`JAL_REG_W-1:0] busy_set_rd;

	// execute parameters
	logic                 exe_valid;
	jal_instr_u           exe_instr;
	logic [`JAL_XLEN-1:0] exe_pc;
	logic                 exe_rvc;
	logic [`JAL_XLEN-1:0] exe_src1;

	jal_issue_buffer u_buffer (
		.CLK            (CLK),
		.reset          (reset),
		.dispatch_valid (dispatch_valid),
		.dispatch_instr (dispatch_instr),
		.dispatch_pc    (dispatch_pc),
		.dispatch_rvc   (dispatch_rvc),
		.pop            (pop),
		.pop_index      (pop_index),
		.slot_valid     (slot_valid),
		.slot_instr     (slot_instr),
		.slot_pc        (slot_pc),
		.slot_rvc       (slot_rvc),
		.buffer_full    (buffer_full)
	);

	jal_issue u_issue (
		.CLK         (CLK),
		.reset       (reset),
		.slot_valid  (slot_valid),
		.slot_instr  (slot_instr),
		.slot_pc     (slot_pc),
		.slot_rvc    (slot_rvc),
		.busy        (busy),
		.rs1_addr    (rs1_addr),
		.rs1_data    (rs1_data),
		.pop         (pop),
		.pop_index   (pop_index),
		.busy_set    (busy_set),
		.busy_set_rd (busy_set_rd),
		.exe_valid   (exe_valid),
		.exe_instr   (exe_instr),
		.exe_pc      (exe_pc),
		.exe_rvc     (exe_rvc),
		.exe_src1    (exe_src1)
	);

	jal_regfile u_regfile (
		.CLK          (CLK),
		.reset        (reset),
		.rs1_addr     (rs1_addr),
		.rs1_data     (rs1_data),
		.busy         (busy),
		.busy_set     (busy_set),
		.busy_set_rd  (busy_set_rd),
		.wb_valid     (wb_valid),
		.wb_rd        (wb_rd),
		.wb_data      (wb_data),
		.ext_wb_valid (ext_wb_valid),
		.ext_wb_rd    (ext_wb_rd),
		.ext_wb_data  (ext_wb_data),
		.ext_busy_set (ext_busy_set),
		.ext_busy_rd  (ext_busy_rd)
	);

	jal_execute u_execute (
		.CLK            (CLK),
		.reset          (reset),
		.exe_valid      (exe_valid),
		.exe_instr      (exe_instr),
		.exe_pc         (exe_pc),
		.exe_rvc        (exe_rvc),
		.exe_src1       (exe_src1),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.wb_valid       (wb_valid),
		.wb_rd          (wb_rd),
		.wb_data        (wb_data)
	);

endmodule

//--- design/jal_execute.sv
`include "jal_consts.svh"

module jal_execute (
	input  logic                  CLK,
	input  logic                  reset,
	input  logic                  exe_valid,
	input  jal_pkg::jal_instr_u   exe_instr,
	input  logic [`JAL_XLEN-1:0]  exe_pc,
	input  logic                  exe_rvc,
	input  logic [`JAL_XLEN-1:0]  exe_src1,
	output logic                  redirect_valid,
	output logic [`JAL_XLEN-1:0]  redirect_pc,
	output logic                  wb_valid,
	output logic [`JAL_REG_W-1:0] wb_rd,
	output logic [`JAL_XLEN-1:0]  wb_data
);
	import jal_pkg::*;

	logic                 is_jal;
	logic [`JAL_XLEN-1:0] j_imm;
	logic [`JAL_XLEN-1:0] i_imm;
	logic [`JAL_XLEN-1:0] link;
	logic [`JAL_XLEN-1:0] target;
	logic [`JAL_REG_W-1:0] rd;

	assign is_jal = exe_instr.j.opcode == JAL_OPC;
	assign rd     = exe_instr.j.rd;

	// 21-bit J offset, bit 0 implied zero
	assign j_imm = {{(`JAL_XLEN-21){exe_instr.j.imm20}}, exe_instr.j.imm20,
		exe_instr.j.imm19_12, exe_instr.j.imm11, exe_instr.j.imm10_1, 1'b0};

	assign i_imm = {{(`JAL_XLEN-12){exe_instr.i.imm11_0[11]}}, exe_instr.i.imm11_0};

	// return address skips a compressed or a full instruction
	assign link = exe_pc + (exe_rvc ? `JAL_XLEN'(2) : `JAL_XLEN'(4));

	// jalr drops bit 0 of the sum
	assign target = is_jal ? exe_pc + j_imm
		: (exe_src1 + i_imm) & ~`JAL_XLEN'(1);

	always_ff @(posedge CLK) begin
		if (reset) begin
			redirect_valid <= 1'b0;
			wb_valid       <= 1'b0;
		end else begin
			redirect_valid <= exe_valid;
			// no writeback to x0
			wb_valid       <= exe_valid && rd != '0;
		end
	end

	always_ff @(posedge CLK) begin
		if (exe_valid) begin
			redirect_pc <= target;
			wb_rd       <= rd;
			wb_data     <= link;
		end
	end

endmodule

//--- design/jal_issue.sv
`include "jal_consts.svh"

module jal_issue (
	input  logic                                             CLK,
	input  logic                                             reset,
	input  logic [`JAL_ISSUE_DEPTH-1:0]                      slot_valid,
	input  jal_pkg::jal_instr_u [`JAL_ISSUE_DEPTH-1:0]       slot_instr,
	input  logic [`JAL_ISSUE_DEPTH-1:0][`JAL_XLEN-1:0]       slot_pc,
	input  logic [`JAL_ISSUE_DEPTH-1:0]                      slot_rvc,
	input  logic [`JAL_NREG-1:0]                             busy,
	output logic [`JAL_REG_W-1:0]                            rs1_addr,
	input  logic [`JAL_XLEN-1:0]                             rs1_data,
	output logic                                             pop,
	output logic [`JAL_ISSUE_IDX_W-1:0]                      pop_index,
	output logic                                             busy_set,
	output logic [`JAL_REG_W-1:0]                            busy_set_rd,
	output logic                                             exe_valid,
	output jal_pkg::jal_instr_u                              exe_instr,
	output logic [`JAL_XLEN-1:0]                             exe_pc,
	output logic                                             exe_rvc,
	output logic [`JAL_XLEN-1:0]                             exe_src1
);
	import jal_pkg::*;

	logic [`JAL_ISSUE_DEPTH-1:0]                 is_jal;
	logic [`JAL_ISSUE_DEPTH-1:0]                 is_jalr;
	logic [`JAL_ISSUE_DEPTH-1:0]                 eligible;
	logic [`JAL_ISSUE_DEPTH-1:0][`JAL_REG_W-1:0] slot_rs1;
	logic [`JAL_ISSUE_IDX_W-1:0]                 pick_idx;
	logic [`JAL_REG_W-1:0]                       pick_rd;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// per slot readiness
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		for (int i = 0; i < `JAL_ISSUE_DEPTH; i++) begin
			is_jal[i]   = slot_instr[i].j.opcode == JAL_OPC;
			is_jalr[i]  = slot_instr[i].i.opcode == JALR_OPC;
			slot_rs1[i] = slot_instr[i].i.rs1;
			// jal never waits, jalr waits on rs1
			eligible[i] = slot_valid[i] & (is_jal[i] | (is_jalr[i] & ~busy[slot_rs1[i]]));
		end
	end

	// lowest eligible slot wins
	always_comb begin
		pick_idx = '0;
		for (int i = `JAL_ISSUE_DEPTH-1; i >= 0; i--) begin
			if (eligible[i]) begin
				pick_idx = `JAL_ISSUE_IDX_W'(i);
			end
		end
	end

	assign pick_rd = slot_instr[pick_idx].i.rd;

	// exe register is always ready, so any eligible slot pops
	assign pop       = |eligible;
	assign pop_index = pick_idx;
	assign rs1_addr  = slot_rs1[pick_idx];

	// claim the link register, x0 is never claimed
	assign busy_set    = pop & (pick_rd != '0);
	assign busy_set_rd = pick_rd;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// execute parameter register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge CLK) begin
		if (reset) begin
			exe_valid <= 1'b0;
		end else begin
			exe_valid <= pop;
		end
	end

	always_ff @(posedge CLK) begin
		if (pop) begin
			exe_instr <= slot_instr[pick_idx];
			exe_pc    <= slot_pc[pick_idx];
			exe_rvc   <= slot_rvc[pick_idx];
			exe_src1  <= rs1_data;
		end
	end

	// the producer of a jalr source keeps it busy, so they never issue back to back
	a_jalr_src_ready: assert property (@(posedge CLK) disable iff (reset)
		exe_valid && exe_instr.i.opcode == JALR_OPC && exe_instr.i.rs1 != '0
		|-> !$past(exe_valid) || $past(exe_instr.j.rd) != exe_instr.i.rs1);

endmodule

//--- design/jal_issue_buffer.sv
`include "jal_consts.svh"

module jal_issue_buffer (
	input  logic                                             CLK,
	input  logic                                             reset,
	input  logic                                             dispatch_valid,
	input  jal_pkg::jal_instr_u                              dispatch_instr,
	input  logic [`JAL_XLEN-1:0]                             dispatch_pc,
	input  logic                                             dispatch_rvc,
	input  logic                                             pop,
	input  logic [`JAL_ISSUE_IDX_W-1:0]                      pop_index,
	output logic [`JAL_ISSUE_DEPTH-1:0]                      slot_valid,
	output jal_pkg::jal_instr_u [`JAL_ISSUE_DEPTH-1:0]       slot_instr,
	output logic [`JAL_ISSUE_DEPTH-1:0][`JAL_XLEN-1:0]       slot_pc,
	output logic [`JAL_ISSUE_DEPTH-1:0]                      slot_rvc,
	output logic                                             buffer_full
);
	import jal_pkg::*;

	logic [`JAL_ISSUE_DEPTH-1:0]       malloc_q;
	logic [`JAL_ISSUE_IDX_W-1:0]       free_idx;
	logic                              push;
	jal_instr_u [`JAL_ISSUE_DEPTH-1:0] instr_q;

	// lowest free slot, from the allocation vector before the edge
	always_comb begin
		free_idx = '0;
		for (int i = `JAL_ISSUE_DEPTH-1; i >= 0; i--) begin
			if (!malloc_q[i]) begin
				free_idx = `JAL_ISSUE_IDX_W'(i);
			end
		end
	end

	assign buffer_full = &malloc_q;
	assign push        = dispatch_valid & ~buffer_full;

	// allocation bits, pop and push may land together on different slots
	always_ff @(posedge CLK) begin
		if (reset) begin
			malloc_q <= '0;
		end else begin
			if (pop) begin
				malloc_q[pop_index] <= 1'b0;
			end
			if (push) begin
				malloc_q[free_idx] <= 1'b1;
			end
		end
	end

	// slot payload
	always_ff @(posedge CLK) begin
		if (push) begin
			instr_q[free_idx]  <= dispatch_instr;
			slot_pc[free_idx]  <= dispatch_pc;
			slot_rvc[free_idx] <= dispatch_rvc;
		end
	end

	assign slot_valid = malloc_q;
	assign slot_instr = instr_q;

	// dispatch must honour buffer_full
	a_no_push_full: assert property (@(posedge CLK) disable iff (reset)
		dispatch_valid |-> !buffer_full);

	// controller only pops what it saw allocated
	a_no_pop_empty: assert property (@(posedge CLK) disable iff (reset)
		pop |-> malloc_q[pop_index]);

endmodule

//--- design/jal_pkg.sv
package jal_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// instruction word views
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// jal immediate is scrambled across the upper 20 bits
	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} jal_jtype_t;

	// jalr view
	typedef struct packed {
		logic [11:0] imm11_0;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} jal_itype_t;

	typedef union packed {
		jal_jtype_t j;
		jal_itype_t i;
	} jal_instr_u;

	localparam logic [6:0] JAL_OPC  = 7'b1101111;
	localparam logic [6:0] JALR_OPC = 7'b1100111;

endpackage

//--- design/jal_regfile.sv
`include "jal_consts.svh"

module jal_regfile (
	input  logic                  CLK,
	input  logic                  reset,
	input  logic [`JAL_REG_W-1:0] rs1_addr,
	output logic [`JAL_XLEN-1:0]  rs1_data,
	output logic [`JAL_NREG-1:0]  busy,
	input  logic                  busy_set,
	input  logic [`JAL_REG_W-1:0] busy_set_rd,
	input  logic                  wb_valid,
	input  logic [`JAL_REG_W-1:0] wb_rd,
	input  logic [`JAL_XLEN-1:0]  wb_data,
	input  logic                  ext_wb_valid,
	input  logic [`JAL_REG_W-1:0] ext_wb_rd,
	input  logic [`JAL_XLEN-1:0]  ext_wb_data,
	input  logic                  ext_busy_set,
	input  logic [`JAL_REG_W-1:0] ext_busy_rd
);

	logic [`JAL_XLEN-1:0] regs_q [`JAL_NREG];
	logic [`JAL_NREG-1:0] busy_q;
	logic [`JAL_NREG-1:0] wr_int;
	logic [`JAL_NREG-1:0] wr_ext;
	logic [`JAL_NREG-1:0] set_any;

	// one-hot decodes, x0 left out
	always_comb begin
		wr_int  = '0;
		wr_ext  = '0;
		set_any = '0;
		for (int r = 1; r < `JAL_NREG; r++) begin
			wr_int[r]  = wb_valid && wb_rd == `JAL_REG_W'(r);
			wr_ext[r]  = ext_wb_valid && ext_wb_rd == `JAL_REG_W'(r);
			set_any[r] = (busy_set && busy_set_rd == `JAL_REG_W'(r))
				|| (ext_busy_set && ext_busy_rd == `JAL_REG_W'(r));
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int r = 0; r < `JAL_NREG; r++) begin
				regs_q[r] <= '0;
			end
			busy_q <= '0;
		end else begin
			for (int r = 1; r < `JAL_NREG; r++) begin
				if (wr_int[r]) begin
					regs_q[r] <= wb_data;
				end
				if (wr_ext[r]) begin
					regs_q[r] <= ext_wb_data;
				end
				// set beats clear
				if (set_any[r]) begin
					busy_q[r] <= 1'b1;
				end else if (wr_int[r] || wr_ext[r]) begin
					busy_q[r] <= 1'b0;
				end
			end
		end
	end

	// x0 is never written so it reads back zero
	assign rs1_data = regs_q[rs1_addr];
	assign busy     = busy_q;

	// execute writeback and external port never collide
	a_no_double_write: assert property (@(posedge CLK) disable iff (reset)
		!(wb_valid && ext_wb_valid && wb_rd == ext_wb_rd && wb_rd != '0));

endmodule

//--- project.f
+incdir+design
design/jal_pkg.sv
design/jal_issue_buffer.sv
design/jal_issue.sv
design/jal_regfile.sv
design/jal_execute.sv
design/jal_core_top.sv
test/tb_jal_core.sv

//--- test/jal_stim.txt
# cmd: P/R rd value | B rd | D instr pc rvc target link exact | I n | X max | Q | F level
# rd, rvc, exact, n, max and level are decimal, the rest is hex
# jal with both immediate signs, rvc on and off, checked for 2 cycle latency
D 100000EF 1000 0 1100 1004 1
Q
D FF9FF16F 2000 1 1FF8 2002 1
Q
D 001001EF 3000 1 3800 3002 1
Q
D 800FF26F 10000 0 F000 10004 1
Q
# jalr on a preloaded base, bit 0 of the sum dropped
P 5 80001000
D 12328367 4000 0 80001122 4004 1
Q
D FFF284E7 4010 1 80000FFE 4012 1
Q
# jalr held while x10 is busy
B 10
D 010505E7 5000 0 A010 5004 0
I 6
R 10 A000
Q
# x0 link gets no writeback, then a jalr off x0
D 0200006F 6000 1 6020 6002 0
D 7FF00667 6100 0 7FE 6104 0
Q
# four jalrs stuck behind x13 fill the buffer
B 13
D 00068767 7000 0 9000 7004 0
D 004687E7 7004 0 9004 7008 0
D 00868867 7008 0 9008 700C 0
D 00C688E7 700C 0 900C 7010 0
F 1
R 13 9000
Q
F 0
# jalr waits on the link of the jal ahead of it
D 040003EF 8000 0 8040 8004 0
D 01038467 8100 1 8014 8102 0
Q
# random gaps between dispatches
D 1000096F A000 0 A100 A004 0
X 3
D FF9FF9EF B000 1 AFF8 B002 0
X 3
D 00100A6F C000 0 C800 C004 0
X 3
D 00090AE7 D000 1 A004 D002 0
Q

//--- test/tb_jal_core.sv
`include "jal_consts.svh"

module tb_jal_core;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int DRAIN_LIMIT = 200;
	localparam int FULL_LIMIT  = 100;

	// one dispatched instruction still waiting for its redirect
	typedef struct packed {
		logic [31:0]          instr;
		logic [`JAL_XLEN-1:0] pc;
		logic                 rvc;
		logic [`JAL_XLEN-1:0] file_target;
		logic [`JAL_XLEN-1:0] file_link;
		logic [31:0]          cyc;
		logic                 exact;
	} pend_t;

	logic                  CLK;
	logic                  reset;
	logic                  dispatch_valid;
	logic [31:0]           dispatch_instr;
	logic [`JAL_XLEN-1:0]  dispatch_pc;
	logic                  dispatch_rvc;
	logic                  buffer_full;
	logic                  ext_wb_valid;
	logic [`JAL_REG_W-1:0] ext_wb_rd;
	logic [`JAL_XLEN-1:0]  ext_wb_data;
	logic                  ext_busy_set;
	logic [`JAL_REG_W-1:0] ext_busy_rd;
	logic                  redirect_valid;
	logic [`JAL_XLEN-1:0]  redirect_pc;
	logic                  wb_valid;
	logic [`JAL_REG_W-1:0] wb_rd;
	logic [`JAL_XLEN-1:0]  wb_data;

	logic [`JAL_XLEN-1:0]  model_regs [`JAL_NREG];
	logic [`JAL_NREG-1:0]  model_busy;
	pend_t                 pend_q [$];
	int                    cyc_cnt = 0;
	integer                seed;

	jal_core_top u_dut (
		.CLK            (CLK),
		.reset          (reset),
		.dispatch_valid (dispatch_valid),
		.dispatch_instr (dispatch_instr),
		.dispatch_pc    (dispatch_pc),
		.dispatch_rvc   (dispatch_rvc),
		.buffer_full    (buffer_full),
		.ext_wb_valid   (ext_wb_valid),
		.ext_wb_rd      (ext_wb_rd),
		.ext_wb_data    (ext_wb_data),
		.ext_busy_set   (ext_busy_set),
		.ext_busy_rd    (ext_busy_rd),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.wb_valid       (wb_valid),
		.wb_rd          (wb_rd),
		.wb_data        (wb_data)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	always @(posedge CLK) cyc_cnt <= cyc_cnt + 1;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference arithmetic and reporting
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// J-type offset straight from the raw word bits
	function automatic logic [63:0] jal_offset(input logic [31:0] w);
		return {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
	endfunction

	function automatic logic [63:0] jalr_offset(input logic [31:0] w);
		return {{52{w[31]}}, w[31:20]};
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic report_mismatch(input string sig, input logic [63:0] exp_val,
		input logic [63:0] act_val);
		fail_run($sformatf("mismatch at %0d ns: %s expected %h got %h",
			$time, sig, exp_val, act_val));
	endtask

	function automatic int find_pending(input logic [4:0] rd);
		for (int k = 0; k < pend_q.size(); k++) begin
			if (pend_q[k].instr[11:7] == rd) begin
				return k;
			end
		end
		return -1;
	endfunction

	// called at the falling edge, outputs are settled here
	task automatic check_outputs();
		int          idx;
		int          lat;
		pend_t       p;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [63:0] base;
		logic [63:0] exp_target;
		logic [63:0] exp_link;
		if (redirect_valid) begin
			idx = find_pending(wb_rd);
			assert (idx >= 0)
				else fail_run($sformatf("redirect for rd %0d with nothing outstanding", wb_rd));
			p = pend_q[idx];
			rd = p.instr[11:7];
			rs1 = p.instr[19:15];
			exp_link = p.pc + (p.rvc ? 64'd2 : 64'd4);
			if (p.instr[6:0] == 7'b1101111) begin
				exp_target = p.pc + jal_offset(p.instr);
			end else begin
				assert (!model_busy[rs1])
					else fail_run($sformatf("jalr rd %0d done while x%0d busy", rd, rs1));
				base = (rs1 == 5'd0) ? 64'd0 : model_regs[rs1];
				exp_target = (base + jalr_offset(p.instr)) & ~64'd1;
			end
			assert (exp_target == p.file_target && exp_link == p.file_link)
				else fail_run($sformatf("stim expectation for rd %0d breaks jump rules", rd));
			assert (redirect_pc == exp_target)
				else report_mismatch("redirect_pc", exp_target, redirect_pc);
			assert (wb_valid == (rd != 5'd0))
				else report_mismatch("wb_valid", 64'(rd != 5'd0), 64'(wb_valid));
			if (wb_valid) begin
				assert (wb_data == exp_link)
					else report_mismatch("wb_data", exp_link, wb_data);
				model_regs[rd] = exp_link;
				model_busy[rd] = 1'b0;
			end
			lat = cyc_cnt - int'(p.cyc) - 1;
			if (p.exact) begin
				assert (lat == 2)
					else report_mismatch("latency", 64'd2, 64'(lat));
			end
			pend_q.delete(idx);
		end else begin
			assert (!wb_valid)
				else fail_run("wb_valid rose without a redirect");
		end
	endtask

	task automatic step();
		@(negedge CLK);
		check_outputs();
		dispatch_valid = 1'b0;
		ext_wb_valid = 1'b0;
		ext_busy_set = 1'b0;
	endtask

	task automatic wait_not_full();
		int waited;
		waited = 0;
		while (buffer_full) begin
			step();
			waited++;
			if (waited > FULL_LIMIT) begin
				fail_run("timeout waiting for buffer_full to fall");
			end
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (pend_q.size() != 0) begin
			step();
			waited++;
			if (waited > DRAIN_LIMIT) begin
				fail_run("timeout waiting for outstanding jumps to complete");
			end
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// command replay
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		int          fd;
		int          code;
		int          num;
		int          ri;
		int          rvc_i;
		int          flag;
		int          gap;
		byte         op;
		string       line;
		string       rest;
		logic [31:0] w;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] c;
		pend_t       p;
		seed = 32'h988b;
		reset = 1'b1;
		dispatch_valid = 1'b0;
		dispatch_instr = '0;
		dispatch_pc = '0;
		dispatch_rvc = 1'b0;
		ext_wb_valid = 1'b0;
		ext_wb_rd = '0;
		ext_wb_data = '0;
		ext_busy_set = 1'b0;
		ext_busy_rd = '0;
		model_busy = '0;
		for (int r = 0; r < `JAL_NREG; r++) begin
			model_regs[r] = '0;
		end
		repeat (8) @(posedge CLK);
		@(negedge CLK);
		reset = 1'b0;
		fd = $fopen("test/jal_stim.txt", "r");
		assert (fd != 0)
			else fail_run("cannot open test/jal_stim.txt");
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code == 0 || line.len() < 2) begin
				continue;
			end
			op = line.getc(0);
			rest = line.substr(1, line.len() - 1);
			case (op)
				"#": begin
				end
				"P", "R": begin
					code = $sscanf(rest, "%d %h", ri, a);
					ext_wb_valid = 1'b1;
					ext_wb_rd = ri[4:0];
					ext_wb_data = a;
					model_regs[ri[4:0]] = a;
					model_busy[ri[4:0]] = 1'b0;
					step();
				end
				"B": begin
					code = $sscanf(rest, "%d", ri);
					ext_busy_set = 1'b1;
					ext_busy_rd = ri[4:0];
					model_busy[ri[4:0]] = 1'b1;
					step();
				end
				"D": begin
					code = $sscanf(rest, "%h %h %d %h %h %d", w, a, rvc_i, b, c, flag);
					wait_not_full();
					p = '{instr: w, pc: a, rvc: rvc_i[0], file_target: b, file_link: c,
						cyc: 32'(cyc_cnt), exact: flag[0]};
					pend_q.push_back(p);
					// issue claims rd, so a later reader sees it busy
					if (w[11:7] != 5'd0) begin
						model_busy[w[11:7]] = 1'b1;
					end
					dispatch_valid = 1'b1;
					dispatch_instr = w;
					dispatch_pc = a;
					dispatch_rvc = rvc_i[0];
					step();
				end
				"I": begin
					code = $sscanf(rest, "%d", num);
					repeat (num) step();
				end
				"X": begin
					code = $sscanf(rest, "%d", num);
					gap = $unsigned($random(seed)) % (num + 1);
					repeat (gap) step();
				end
				"Q": begin
					drain();
				end
				"F": begin
					code = $sscanf(rest, "%d", num);
					assert (buffer_full == num[0])
						else report_mismatch("buffer_full", 64'(num[0]), 64'(buffer_full));
				end
				default: begin
					fail_run($sformatf("unknown stim command %s", line));
				end
			endcase
		end
		$fclose(fd);
		drain();
		if (pend_q.size() == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			fail_run("jumps still outstanding at the end of the run");
		end
	end

endmodule
